//--- compile.f
hw/connect_four_pkg.sv
hw/move_decoder.sv
hw/board_memory.sv
hw/win_detector.sv
hw/cell_painter.sv
hw/connect_four_top.sv
test/connect_four_assert.sv
test/connect_four_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Connect Four testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module connect_four_tb -o connect_four_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/connect_four_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- test/connect_four_tb.sv
module connect_four_tb import connect_four_pkg::*; ();

	localparam int TOTAL_MOVES = 33;
	localparam int MOVE_CYCLES = 40;
	localparam int CYCLE_LIMIT = MOVE_CYCLES * TOTAL_MOVES + 400;	// Resets and stray keys
	localparam int VERT_COLS [7]  = '{2, 3, 2, 3, 2, 3, 2};
	localparam int DIAG_COLS [12] = '{6, 0, 1, 1, 2, 3, 2, 2, 3, 6, 3, 3};

	logic                clk;
	logic                reset_n;
	logic                key_valid;
	logic [7:0]          key_code;
	logic                plot;
	logic [X_W-1:0]      x;
	logic [Y_W-1:0]      y;
	logic [COLOUR_W-1:0] colour;
	logic [PLAYER_W-1:0] turn;
	logic [PLAYER_W-1:0] winner;
	logic                game_over;

	integer seed;
	int     errors;
	int     tests;
	int     failed_tests;
	int     mark;
	int     cycles;
	int     fill [BOARD_COLS];	// Column heights as the rules predict
	logic   over;

	connect_four_top dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [7:0] column_key(input int col);
		case (col)
			0: return KEY_Z;
			1: return KEY_X;
			2: return KEY_C;
			3: return KEY_V;
			4: return KEY_B;
			5: return KEY_N;
			default: return KEY_M;
		endcase
	endfunction

	function automatic logic is_column_code(input logic [7:0] code);
		for (int c = 0; c < BOARD_COLS; c++)
		begin
			if (code == column_key(c))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic send_key(input logic [7:0] code);
		@(posedge clk);
		key_valid <= 1'b1;
		key_code  <= code;
	endtask

	task automatic release_keys();
		@(posedge clk);
		key_valid <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_n <= 1'b0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		fill = '{default: 0};
		over = 1'b0;
	endtask

	// Column key, then space, then wait for the square and the check
	task automatic play_move(input int col, input logic [PLAYER_W-1:0] exp_winner);
		logic accept;
		logic done_seen;
		accept    = !over && fill[col] < BOARD_ROWS;
		done_seen = 1'b0;
		send_key(column_key(col));
		send_key(KEY_SPACE);
		release_keys();
		if (accept)
		begin
			do
			begin
				@(negedge clk);
				if (dut.check_done)
					done_seen = 1'b1;
			end
			while (!done_seen || plot);
			fill[col]++;
		end
		else
			repeat (6) @(negedge clk);	// Past the slot of a first plot
		over = over || (exp_winner != PLAYER_NONE);
		if (winner !== exp_winner || game_over !== over)
		begin
			$display("[FAIL] %0t: winner %0d game_over %0b, expected winner %0d",
				$time, winner, game_over, exp_winner);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		int total;
		total = errors + dut.u_assert.failures;
		tests++;
		if (total != mark)
		begin
			failed_tests++;
			$display("Test %0d (%s): %0d failed checks", tests, name, total - mark);
		end
		else
			$display("Test %0d (%s): ok", tests, name);
		mark = total;
	endtask

	initial
	begin
		integer     rnd;
		logic [7:0] code;
		int         total;
		seed      = 32'hded22803;
		reset_n   <= 1'b0;
		key_valid <= 1'b0;
		key_code  <= 8'h00;
		apply_reset();

		// No column chosen yet, so none of this may drop
		send_key(KEY_SPACE);
		for (int i = 0; i < 8; i++)
		begin
			do
			begin
				rnd  = $random(seed);
				code = rnd[7:0];
			end
			while (is_column_code(code) || code == KEY_SPACE);
			send_key(code);
		end
		send_key(KEY_SPACE);
		release_keys();
		repeat (6) @(negedge clk);
		finish_test("stray keys");

		play_move(0, PLAYER_NONE);
		play_move(0, PLAYER_NONE);
		play_move(6, PLAYER_NONE);
		play_move(3, PLAYER_NONE);
		finish_test("placement and plot timing");

		for (int i = 0; i < BOARD_ROWS + 1; i++)
			play_move(1, PLAYER_NONE);	// Eighth drop finds the column full
		finish_test("alternation and full column");

		apply_reset();
		for (int i = 0; i < 7; i++)
			play_move(VERT_COLS[i], (i == 6) ? PLAYER_ONE : PLAYER_NONE);
		play_move(4, PLAYER_ONE);
		finish_test("vertical four");

		// Player two builds the rising diagonal from column 0
		apply_reset();
		for (int i = 0; i < 12; i++)
			play_move(DIAG_COLS[i], (i == 11) ? PLAYER_TWO : PLAYER_NONE);
		play_move(5, PLAYER_TWO);
		finish_test("diagonal four");

		total = errors + dut.u_assert.failures;
		$display("Tests: %0d, failed tests: %0d, failed checks: %0d", tests, failed_tests, total);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- test/connect_four_assert.sv
module connect_four_assert import connect_four_pkg::*; (
	input logic                clk,
	input logic                reset_n,
	input logic                key_valid,
	input logic [7:0]          key_code,
	input logic                drop_req,
	input logic [COL_W-1:0]    drop_col,
	input logic                placed,
	input logic [COL_W-1:0]    placed_col,
	input logic [ROW_W-1:0]    placed_row,
	input logic [PLAYER_W-1:0] placed_player,
	input logic [PLAYER_W-1:0] turn,
	input logic                plot,
	input logic [X_W-1:0]      x,
	input logic [Y_W-1:0]      y,
	input logic [COLOUR_W-1:0] colour,
	input logic [PLAYER_W-1:0] winner,
	input logic                game_over
);

	int                  fill [BOARD_COLS];	// Pieces seen per column
	int                  plot_run;	// Plot cycles so far in this square
	int                  failures;
	int                  org_x;
	int                  org_y;
	int                  sel_col;	// Column of the latest letter key
	logic                col_seen;
	logic                odd_move;	// Set while player two is to move
	logic [PLAYER_W-1:0] exp_player;
	logic [COLOUR_W-1:0] exp_colour;	// Colour of the square being drawn

	// Column chosen by a key code, -1 for any other key
	function automatic int key_column(input logic [7:0] code);
		case (code)
			KEY_Z: return 0;
			KEY_X: return 1;
			KEY_C: return 2;
			KEY_V: return 3;
			KEY_B: return 4;
			KEY_N: return 5;
			KEY_M: return 6;
			default: return -1;
		endcase
	endfunction

	// Square origin of the newest piece
	assign org_x = CELL_X0 + CELL_PITCH_X * int'(placed_col);
	assign org_y = CELL_Y0 + CELL_PITCH_Y * int'(placed_row);

	assign exp_player = odd_move ? PLAYER_TWO : PLAYER_ONE;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			fill       <= '{default: 0};
			col_seen   <= 1'b0;
			sel_col    <= 0;
			odd_move   <= 1'b0;	// Player one opens every game
			exp_colour <= COLOUR_ONE;
			plot_run   <= 0;
		end
		else
		begin
			if (placed)
			begin
				fill[placed_col] <= fill[placed_col] + 1;
				odd_move         <= !odd_move;
				exp_colour       <= odd_move ? COLOUR_TWO : COLOUR_ONE;
			end
			if (key_valid && key_column(key_code) >= 0)
			begin
				col_seen <= 1'b1;
				sel_col  <= key_column(key_code);
			end
			plot_run <= plot ? plot_run + 1 : 0;
		end
	end

	////////////////////////////////////////////////////////////
	// Key handling and drops
	////////////////////////////////////////////////////////////
	assert property (@(posedge clk) disable iff (!reset_n)
		drop_req |-> col_seen && $past(key_valid && key_code == KEY_SPACE))
	else
	begin
		failures++;
		$error("Drop request without a column key and a space strobe");
	end

	// Chosen column, landing row, turn order and strobe to placement latency
	assert property (@(posedge clk) disable iff (!reset_n)
		placed |-> $past(key_valid && key_code == KEY_SPACE, 2)
			&& int'(placed_col) == sel_col
			&& int'(placed_row) == BOARD_ROWS - 1 - fill[placed_col]
			&& placed_player == exp_player)
	else
	begin
		failures++;
		$error("Placement at wrong column, row, time or player");
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		!placed |-> turn == exp_player)
	else
	begin
		failures++;
		$error("Turn does not follow the move order");
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		drop_req && fill[drop_col] >= BOARD_ROWS |=> !placed && $stable(turn))
	else
	begin
		failures++;
		$error("Drop into a full column was not ignored");
	end

	////////////////////////////////////////////////////////////
	// Pixel writes
	////////////////////////////////////////////////////////////
	assert property (@(posedge clk) disable iff (!reset_n)
		plot |-> int'(x) >= org_x && int'(x) < org_x + CELL_SIZE
			&& int'(y) >= org_y && int'(y) < org_y + CELL_SIZE
			&& colour == exp_colour
			&& plot_run < CELL_SIZE * CELL_SIZE
			&& (plot_run != 0 || $past(placed)))
	else
	begin
		failures++;
		$error("Pixel write outside the square, in the wrong colour or late");
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		$fell(plot) |-> plot_run == CELL_SIZE * CELL_SIZE)
	else
	begin
		failures++;
		$error("Square was not 36 consecutive plot cycles");
	end

	// Result holds and the board is frozen
	assert property (@(posedge clk) disable iff (!reset_n)
		game_over |=> game_over && $stable(winner) && !placed && winner != PLAYER_NONE)
	else
	begin
		failures++;
		$error("Game over state not held");
	end

endmodule

bind connect_four_top connect_four_assert u_assert (.*);

//--- hw/connect_four_top.sv
module connect_four_top import connect_four_pkg::*; (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                key_valid,
	input  logic [7:0]          key_code,
	output logic                plot,
	output logic [X_W-1:0]      x,
	output logic [Y_W-1:0]      y,
	output logic [COLOUR_W-1:0] colour,
	output logic [PLAYER_W-1:0] turn,
	output logic [PLAYER_W-1:0] winner,
	output logic                game_over
);

	logic                drop_req;
	logic [COL_W-1:0]    drop_col;
	logic [COL_W-1:0]    rd_col;
	logic [ROW_W-1:0]    rd_row;
	logic [PLAYER_W-1:0] rd_player;
	logic                placed;
	logic [COL_W-1:0]    placed_col;
	logic [ROW_W-1:0]    placed_row;
	logic [PLAYER_W-1:0] placed_player;
	logic                painter_active, detector_active;
	logic                check_done;
	logic                busy;

	// No new drop until drawing and checking are both finished
	assign busy = painter_active || detector_active;

	move_decoder u_decoder (
		.clk(clk), .reset_n(reset_n), .key_valid(key_valid), .key_code(key_code),
		.drop_req(drop_req), .drop_col(drop_col)
	);

	board_memory u_board (
		.clk(clk), .reset_n(reset_n), .drop_req(drop_req), .drop_col(drop_col),
		.busy(busy), .game_over(game_over), .rd_col(rd_col), .rd_row(rd_row),
		.rd_player(rd_player), .placed(placed), .placed_col(placed_col),
		.placed_row(placed_row), .placed_player(placed_player), .turn(turn)
	);

	win_detector u_detector (
		.clk(clk), .reset_n(reset_n), .placed(placed), .placed_col(placed_col),
		.placed_row(placed_row), .placed_player(placed_player), .rd_player(rd_player),
		.rd_col(rd_col), .rd_row(rd_row), .active(detector_active),
		.check_done(check_done), .winner(winner), .game_over(game_over)
	);

	cell_painter u_painter (
		.clk(clk), .reset_n(reset_n), .placed(placed), .placed_col(placed_col),
		.placed_row(placed_row), .placed_player(placed_player), .active(painter_active),
		.plot(plot), .x(x), .y(y), .colour(colour)
	);

endmodule

//--- hw/cell_painter.sv
module cell_painter import connect_four_pkg::*; (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                placed,
	input  logic [COL_W-1:0]    placed_col,
	input  logic [ROW_W-1:0]    placed_row,
	input  logic [PLAYER_W-1:0] placed_player,
	output logic                active,
	output logic                plot,
	output logic [X_W-1:0]      x,
	output logic [Y_W-1:0]      y,
	output logic [COLOUR_W-1:0] colour
);

	logic [X_W-1:0]    org_x;
	logic [Y_W-1:0]    org_y;
	logic [SCAN_W-1:0] px, py;	// Offset inside the square
	logic              last_px, last_py;

	assign last_px = (px == SCAN_W'(CELL_SIZE - 1));
	assign last_py = (py == SCAN_W'(CELL_SIZE - 1));

	// Busy from the placement pulse on, so no drop slips in
	assign active = placed || plot;

	assign x = org_x + X_W'(px);
	assign y = org_y + Y_W'(py);

	////////////////////////////////////////////////////////////
	// Square scan, x fastest
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			plot <= 1'b0;
			px   <= '0;
			py   <= '0;
		end
		else if (placed)
		begin
			plot <= 1'b1;
			px   <= '0;
			py   <= '0;
		end
		else if (plot)
		begin
			if (last_px)
			begin
				px <= '0;
				py <= py + 1'b1;
				if (last_py)
					plot <= 1'b0;	// 36th pixel done
			end
			else
				px <= px + 1'b1;
		end
	end

	// Cell origin and player colour
	always_ff @(posedge clk)
	begin
		if (placed)
		begin
			org_x  <= X_W'(CELL_X0) + X_W'(CELL_PITCH_X) * X_W'(placed_col);
			org_y  <= Y_W'(CELL_Y0) + Y_W'(CELL_PITCH_Y) * Y_W'(placed_row);
			colour <= (placed_player == PLAYER_ONE) ? COLOUR_ONE : COLOUR_TWO;
		end
	end

endmodule

//--- hw/win_detector.sv
module win_detector import connect_four_pkg::*; (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                placed,
	input  logic [COL_W-1:0]    placed_col,
	input  logic [ROW_W-1:0]    placed_row,
	input  logic [PLAYER_W-1:0] placed_player,
	input  logic [PLAYER_W-1:0] rd_player,
	output logic [COL_W-1:0]    rd_col,
	output logic [ROW_W-1:0]    rd_row,
	output logic                active,
	output logic                check_done,
	output logic [PLAYER_W-1:0] winner,
	output logic                game_over
);

	logic [DET_STATE_W-1:0] state;
	logic [1:0]             dir;	// 0 horiz, 1 vert, 2 down-right, 3 down-left
	logic                   sense;	// Set while walking the negative way
	logic [1:0]             steps;
	logic [PLAYER_W-1:0]    player;
	logic signed [ROW_W:0]  org_c, org_r, pos_c, pos_r;
	logic signed [ROW_W:0]  dc, dr;
	logic                   in_bounds, hit, win_hit;
	logic                   adv, flip, next_dir;

	// Unit step of a direction, positive sense
	function automatic logic signed [ROW_W:0] step_c(input logic [1:0] d);
		return (d == 2'd1) ? 4'sd0 : ((d == 2'd3) ? -4'sd1 : 4'sd1);
	endfunction

	function automatic logic signed [ROW_W:0] step_r(input logic [1:0] d);
		return (d == 2'd0) ? 4'sd0 : 4'sd1;
	endfunction

	assign dc = sense ? -step_c(dir) : step_c(dir);
	assign dr = sense ? -step_r(dir) : step_r(dir);

	assign in_bounds = (pos_c >= 0) && (pos_c < BOARD_COLS) && (pos_r >= 0) && (pos_r < BOARD_ROWS);
	assign hit       = in_bounds && (rd_player == player);
	assign win_hit   = hit && (int'(steps) + 2 >= WIN_LENGTH);	// 1 + steps after this one

	assign adv      = (state == DET_WALK) && hit && !win_hit;
	assign flip     = (state == DET_WALK) && !hit && !sense;
	assign next_dir = (state == DET_WALK) && !hit && sense && (dir != 2'd3);

	assign rd_col     = pos_c[COL_W-1:0];
	assign rd_row     = pos_r[ROW_W-1:0];
	assign active     = (state != DET_IDLE);
	assign check_done = (state == DET_DONE);

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state     <= DET_IDLE;
			dir       <= 2'd0;
			sense     <= 1'b0;
			steps     <= 2'd0;
			winner    <= PLAYER_NONE;
			game_over <= 1'b0;
		end
		else
		begin
			case (state)
				DET_IDLE:
				begin
					if (placed)
					begin
						state <= DET_WALK;
						dir   <= 2'd0;
						sense <= 1'b0;
						steps <= 2'd0;
					end
				end
				DET_WALK:
				begin
					if (win_hit)
					begin
						winner    <= player;	// Held until reset
						game_over <= 1'b1;
						state     <= DET_DONE;
					end
					else if (adv)
						steps <= steps + 1'b1;
					else if (flip)
						sense <= 1'b1;
					else if (next_dir)
					begin
						dir   <= dir + 1'b1;
						sense <= 1'b0;
						steps <= 2'd0;
					end
					else
						state <= DET_DONE;	// All four lines short
				end
				default: state <= DET_IDLE;
			endcase
		end
	end

	// Walk position, starts one step right of the new piece
	always_ff @(posedge clk)
	begin
		if (placed && state == DET_IDLE)
		begin
			org_c  <= $signed({1'b0, placed_col});
			org_r  <= $signed({1'b0, placed_row});
			pos_c  <= $signed({1'b0, placed_col}) + 4'sd1;
			pos_r  <= $signed({1'b0, placed_row});
			player <= placed_player;
		end
		else if (adv)
		begin
			pos_c <= pos_c + dc;
			pos_r <= pos_r + dr;
		end
		else if (flip)
		begin
			pos_c <= org_c - step_c(dir);
			pos_r <= org_r - step_r(dir);
		end
		else if (next_dir)
		begin
			pos_c <= org_c + step_c(dir + 2'd1);
			pos_r <= org_r + step_r(dir + 2'd1);
		end
	end

endmodule

//--- hw/board_memory.sv
module board_memory import connect_four_pkg::*; (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                drop_req,
	input  logic [COL_W-1:0]    drop_col,
	input  logic                busy,
	input  logic                game_over,
	input  logic [COL_W-1:0]    rd_col,
	input  logic [ROW_W-1:0]    rd_row,
	output logic [PLAYER_W-1:0] rd_player,
	output logic                placed,
	output logic [COL_W-1:0]    placed_col,
	output logic [ROW_W-1:0]    placed_row,
	output logic [PLAYER_W-1:0] placed_player,
	output logic [PLAYER_W-1:0] turn
);

	logic [PLAYER_W-1:0] cells [BOARD_ROWS][BOARD_COLS];
	logic [ROW_W-1:0]    counts [BOARD_COLS];	// Pieces per column

	logic [ROW_W-1:0] col_count;
	logic [ROW_W-1:0] land_row;
	logic             col_full;
	logic             accept;

	////////////////////////////////////////////////////////////
	// Drop decision
	////////////////////////////////////////////////////////////
	assign col_count = counts[drop_col];
	assign col_full  = (col_count >= ROW_W'(BOARD_ROWS));
	assign land_row  = ROW_W'(BOARD_ROWS - 1) - col_count;	// Lowest free row

	// Full column, busy engine or finished game drop the request
	assign accept = drop_req && !busy && !game_over && !col_full;

	// Read port for the win detector
	assign rd_player = cells[rd_row][rd_col];

	////////////////////////////////////////////////////////////
	// Cell array and fill counts
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			for (int r = 0; r < BOARD_ROWS; r++)
			begin
				for (int c = 0; c < BOARD_COLS; c++)
				begin
					cells[r][c] <= PLAYER_NONE;
				end
			end
			for (int c = 0; c < BOARD_COLS; c++)
			begin
				counts[c] <= '0;
			end
		end
		else if (accept)
		begin
			cells[land_row][drop_col] <= turn;
			counts[drop_col]          <= col_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Turn and placement strobe
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			placed <= 1'b0;
			turn   <= PLAYER_ONE;
		end
		else
		begin
			placed <= accept;
			if (accept)
			begin
				turn <= (turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
			end
		end
	end

	// Where the new piece went
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			placed_col    <= drop_col;
			placed_row    <= land_row;
			placed_player <= turn;
		end
	end

endmodule

//--- hw/move_decoder.sv
module move_decoder import connect_four_pkg::*; (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             key_valid,
	input  logic [7:0]       key_code,
	output logic             drop_req,
	output logic [COL_W-1:0] drop_col
);

	logic has_column;	// A column key was seen since reset

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			drop_req   <= 1'b0;
			drop_col   <= '0;
			has_column <= 1'b0;
		end
		else
		begin
			drop_req <= 1'b0;
			if (key_valid)
			begin
				case (key_code)
					KEY_Z: drop_col <= 3'd0;
					KEY_X: drop_col <= 3'd1;
					KEY_C: drop_col <= 3'd2;
					KEY_V: drop_col <= 3'd3;
					KEY_B: drop_col <= 3'd4;
					KEY_N: drop_col <= 3'd5;
					KEY_M: drop_col <= 3'd6;
					KEY_SPACE: drop_req <= has_column;
					default: ;	// Unknown codes are dropped
				endcase

				// Any letter key arms the confirm
				if (key_code inside {KEY_Z, KEY_X, KEY_C, KEY_V, KEY_B, KEY_N, KEY_M})
				begin
					has_column <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/connect_four_pkg.sv
package connect_four_pkg;

	////////////////////////////////////////////////////////////
	// Board geometry
	////////////////////////////////////////////////////////////
	localparam int BOARD_COLS = 7;
	localparam int BOARD_ROWS = 7;	// Row 0 at top, pieces fill from row 6
	localparam int WIN_LENGTH = 4;

	localparam int COL_W    = 3;
	localparam int ROW_W    = 3;
	localparam int X_W      = 8;	// 160 wide frame
	localparam int Y_W      = 7;	// 120 high frame
	localparam int PLAYER_W = 2;
	localparam int COLOUR_W = 3;
	localparam int SCAN_W   = 3;	// Pixel counters inside one cell

	// Player codes, also the cell contents
	localparam logic [PLAYER_W-1:0] PLAYER_NONE = 2'd0;
	localparam logic [PLAYER_W-1:0] PLAYER_ONE  = 2'd1;
	localparam logic [PLAYER_W-1:0] PLAYER_TWO  = 2'd2;

	localparam logic [COLOUR_W-1:0] COLOUR_ONE = 3'b100;	// Red
	localparam logic [COLOUR_W-1:0] COLOUR_TWO = 3'b001;	// Blue

	////////////////////////////////////////////////////////////
	// Keyboard make codes
	////////////////////////////////////////////////////////////
	localparam logic [7:0] KEY_Z     = 8'h1A;
	localparam logic [7:0] KEY_X     = 8'h22;
	localparam logic [7:0] KEY_C     = 8'h21;
	localparam logic [7:0] KEY_V     = 8'h2A;
	localparam logic [7:0] KEY_B     = 8'h32;
	localparam logic [7:0] KEY_N     = 8'h31;
	localparam logic [7:0] KEY_M     = 8'h3A;
	localparam logic [7:0] KEY_SPACE = 8'h29;

	// Top-left pixel of a cell is (X0 + PITCH_X*c, Y0 + PITCH_Y*r)
	localparam int CELL_X0      = 8;
	localparam int CELL_PITCH_X = 22;
	localparam int CELL_Y0      = 5;
	localparam int CELL_PITCH_Y = 16;
	localparam int CELL_SIZE    = 6;

	// Win detector FSM
	localparam int DET_STATE_W = 2;
	localparam logic [DET_STATE_W-1:0] DET_IDLE = 2'd0;
	localparam logic [DET_STATE_W-1:0] DET_WALK = 2'd1;
	localparam logic [DET_STATE_W-1:0] DET_DONE = 2'd2;

endpackage
